// ==== Makefile ====
SRCS := $(shell cat list.f)

.PHONY: run clean

obj_dir/Vtb_top: list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f list.f

run: obj_dir/Vtb_top
	out="$$(./obj_dir/Vtb_top +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// ==== list.f ====
verilog/bus_pkg.sv
verilog/split_pkg.sv
verilog/split_ifs.sv
verilog/ar_splitter.sv
verilog/burst_slot.sv
verilog/slot_alloc.sv
verilog/r_beat_tagger.sv
verilog/read_burst_splitter.sv
tb/tb_checker.sv
tb/tb_props.sv
tb/tb_top.sv

// ==== tb/ar_stim.txt ====
// One AR burst per line, all values in hex
// id  addr      len  size  burst (0 FIXED, 1 INCR)
1 00001000 00 2 1
2 00002000 03 2 1
3 00003000 02 0 0
1 00004000 07 1 1
4 00005004 00 2 0
2 00006000 05 3 1
5 00007000 01 2 0
6 00008000 03 2 1
7 00009000 0f 2 1
3 0000a000 00 1 1
8 0000b000 02 2 0
1 0000c010 04 0 1
9 0000d000 00 3 1

// ==== tb/tb_checker.sv ====
`timescale 1ns/1ns

module tb_checker (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  bus_pkg::id_t     ar_id_i,
  input  bus_pkg::addr_t   ar_addr_i,
  input  bus_pkg::len_t    ar_len_i,
  input  bus_pkg::size_t   ar_size_i,
  input  bus_pkg::burst_t  ar_burst_i,
  input  logic             ar_valid_i,
  input  logic             ar_ready_i,
  input  bus_pkg::id_t     dn_id_i,
  input  bus_pkg::addr_t   dn_addr_i,
  input  bus_pkg::size_t   dn_size_i,
  input  bus_pkg::burst_t  dn_burst_i,
  input  logic             dn_valid_i,
  input  logic             dn_ready_i,
  input  bus_pkg::id_t     r_id_i,
  input  bus_pkg::data_t   r_data_i,
  input  bus_pkg::resp_t   r_resp_i,
  input  logic             r_last_i,
  input  logic             r_valid_i,
  input  logic             r_ready_i
);
  import bus_pkg::*;

  // Expected downstream ARs in issue order as {id, addr, size, burst}
  logic [40:0] exp_ar_q [$];
  // Expected upstream R beats as {id, data, last}
  logic [36:0] exp_r_q [$];

  int err_cnt   = 0;
  int ar_up_cnt = 0;
  int ar_dn_cnt = 0;
  int r_cnt     = 0;

  function automatic void compare_field(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s = %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endfunction

  // --------------------------------------------------------------------------
  // Expected beats follow each accepted upstream burst
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin : watch
    addr_t       a;
    logic [40:0] ar;
    logic [36:0] r;
    int          idx;
    if (rst_n_i) begin
      if (ar_valid_i && ar_ready_i) begin
        a = ar_addr_i;
        for (int i = 0; i <= int'(ar_len_i); i++) begin
          exp_ar_q.push_back({ar_id_i, a, ar_size_i, ar_burst_i});
          exp_r_q.push_back({ar_id_i, a, i == int'(ar_len_i)});
          // INCR steps by the beat size and FIXED stays put
          if (ar_burst_i == BURST_INCR) begin
            a = a + (addr_t'(1) << ar_size_i);
          end
        end
        ar_up_cnt++;
      end

      if (dn_valid_i && dn_ready_i) begin
        ar_dn_cnt++;
        if (exp_ar_q.size() == 0) begin
          $display("Downstream AR to %h was issued with no burst left to split", dn_addr_i);
          err_cnt++;
        end else begin
          ar = exp_ar_q.pop_front();
          compare_field("m_ar_id_o", 32'(dn_id_i), 32'(ar[40:37]));
          compare_field("m_ar_addr_o", dn_addr_i, ar[36:5]);
          compare_field("m_ar_size_o", 32'(dn_size_i), 32'(ar[4:2]));
          compare_field("m_ar_burst_o", 32'(dn_burst_i), 32'(ar[1:0]));
        end
      end

      if (r_valid_i && r_ready_i) begin
        r_cnt++;
        // Oldest expected beat of this ID
        idx = -1;
        for (int i = exp_r_q.size() - 1; i >= 0; i--) begin
          if (exp_r_q[i][36:33] == r_id_i) begin
            idx = i;
          end
        end
        if (idx < 0) begin
          $display("R beat with ID %h arrived upstream with no burst waiting", r_id_i);
          err_cnt++;
        end else begin
          r = exp_r_q[idx];
          exp_r_q.delete(idx);
          compare_field("s_r_data_o", r_data_i, r[32:1]);
          // Response is bits 3:2 of the beat address
          compare_field("s_r_resp_o", 32'(r_resp_i), 32'(r[4:3]));
          compare_field("s_r_last_o", 32'(r_last_i), 32'(r[0]));
        end
      end
    end
  end

  // Totals against the stim file and the closing count line
  function automatic int close_report(int n_bursts, int n_beats, int other_errs);
    if (ar_up_cnt != n_bursts || ar_dn_cnt != n_beats || r_cnt != n_beats) begin
      $display("Transfer counts do not match the %0d bursts and %0d beats of the stim file",
               n_bursts, n_beats);
      err_cnt++;
    end
    if (exp_ar_q.size() != 0 || exp_r_q.size() != 0) begin
      $display("%0d downstream ARs and %0d R beats were never seen",
               exp_ar_q.size(), exp_r_q.size());
      err_cnt++;
    end
    $display("Errors %0d, upstream ARs %0d, downstream ARs %0d, R beats %0d",
             err_cnt + other_errs, ar_up_cnt, ar_dn_cnt, r_cnt);
    return err_cnt + other_errs;
  endfunction

endmodule

// ==== tb/tb_props.sv ====
`timescale 1ns/1ns

module tb_props (
  input logic             clk_i,
  input logic             rst_n_i,
  input bus_pkg::id_t     ar_id_i,
  input logic             ar_valid_i,
  input logic             ar_ready_i,
  input bus_pkg::addr_t   dn_addr_i,
  input logic             dn_valid_i,
  input logic             dn_ready_i,
  input bus_pkg::id_t     r_id_i,
  input bus_pkg::data_t   r_data_i,
  input logic             r_last_i,
  input logic             r_valid_i,
  input logic             r_ready_i
);
  import split_pkg::*;

  // IDs with a burst in flight
  logic [15:0] busy_ids;
  int          fail_cnt = 0;

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_ids <= '0;
    end else begin
      if (r_valid_i && r_ready_i && r_last_i) begin
        busy_ids[r_id_i] <= 1'b0;
      end
      if (ar_valid_i && ar_ready_i) begin
        busy_ids[ar_id_i] <= 1'b1;
      end
    end
  end

  id_reuse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_valid_i && ar_ready_i |-> !busy_ids[ar_id_i])
    else begin
      $error("AR accepted while its ID still has a burst in flight");
      fail_cnt++;
    end

  outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $countones(busy_ids) <= MAX_TXNS)
    else begin
      $error("More bursts in flight than there are slots");
      fail_cnt++;
    end

  dn_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dn_valid_i && !dn_ready_i |=> dn_valid_i && $stable(dn_addr_i))
    else begin
      $error("Downstream AR dropped or changed before ready");
      fail_cnt++;
    end

  r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i) && $stable(r_id_i))
    else begin
      $error("Upstream R dropped or changed before ready");
      fail_cnt++;
    end

endmodule

bind read_burst_splitter tb_props i_tb_props (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .ar_id_i    (s_ar_id_i),
  .ar_valid_i (s_ar_valid_i),
  .ar_ready_i (s_ar_ready_o),
  .dn_addr_i  (m_ar_addr_o),
  .dn_valid_i (m_ar_valid_o),
  .dn_ready_i (m_ar_ready_i),
  .r_id_i     (s_r_id_o),
  .r_data_i   (s_r_data_o),
  .r_last_i   (s_r_last_o),
  .r_valid_i  (s_r_valid_o),
  .r_ready_i  (s_r_ready_i)
);

// ==== tb/tb_top.sv ====
`timescale 1ns/1ns

module tb_top;
  import bus_pkg::*;

  localparam int MAX_BURSTS = 64;
  localparam int TIMEOUT    = 2000;

  logic   clk_i;
  logic   rst_n_i;
  id_t    s_ar_id_i;
  addr_t  s_ar_addr_i;
  len_t   s_ar_len_i;
  size_t  s_ar_size_i;
  burst_t s_ar_burst_i;
  logic   s_ar_valid_i;
  logic   s_ar_ready_o;
  id_t    m_ar_id_o;
  addr_t  m_ar_addr_o;
  size_t  m_ar_size_o;
  burst_t m_ar_burst_o;
  logic   m_ar_valid_o;
  logic   m_ar_ready_i = 1'b0;
  id_t    m_r_id_i     = '0;
  data_t  m_r_data_i   = '0;
  resp_t  m_r_resp_i   = '0;
  logic   m_r_valid_i  = 1'b0;
  logic   m_r_ready_o;
  id_t    s_r_id_o;
  data_t  s_r_data_o;
  resp_t  s_r_resp_o;
  logic   s_r_last_o;
  logic   s_r_valid_o;
  logic   s_r_ready_i  = 1'b0;

  // Five words per burst as id, addr, len, size and burst kind
  logic [31:0] stim_mem [5*MAX_BURSTS];
  // Downstream ARs waiting for their R beat as {id, addr}
  logic [35:0] pend_q [$];
  logic        r_taken = 1'b0;
  int          n_bursts;
  int          n_beats;
  int          errs;
  string       stall;

  read_burst_splitter i_read_burst_splitter (.*);

  tb_checker i_tb_checker (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ar_id_i    (s_ar_id_i),
    .ar_addr_i  (s_ar_addr_i),
    .ar_len_i   (s_ar_len_i),
    .ar_size_i  (s_ar_size_i),
    .ar_burst_i (s_ar_burst_i),
    .ar_valid_i (s_ar_valid_i),
    .ar_ready_i (s_ar_ready_o),
    .dn_id_i    (m_ar_id_o),
    .dn_addr_i  (m_ar_addr_o),
    .dn_size_i  (m_ar_size_o),
    .dn_burst_i (m_ar_burst_o),
    .dn_valid_i (m_ar_valid_o),
    .dn_ready_i (m_ar_ready_i),
    .r_id_i     (s_r_id_o),
    .r_data_i   (s_r_data_o),
    .r_resp_i   (s_r_resp_o),
    .r_last_i   (s_r_last_o),
    .r_valid_i  (s_r_valid_o),
    .r_ready_i  (s_r_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Downstream responder
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_n_i && m_ar_valid_o && m_ar_ready_i) begin
      pend_q.push_back({m_ar_id_o, m_ar_addr_o});
    end
    if (m_r_valid_i && m_r_ready_o) begin
      r_taken = 1'b1;
    end
  end

  // Random ID among the pending ones and the oldest beat of that ID first
  always @(negedge clk_i) begin : respond
    int k;
    int j;
    if (rst_n_i) begin
      m_ar_ready_i = ($urandom_range(0, 3) != 0);
      s_r_ready_i  = ($urandom_range(0, 3) != 0);
      if (r_taken) begin
        m_r_valid_i = 1'b0;
        r_taken     = 1'b0;
      end
      if (!m_r_valid_i && pend_q.size() > 0 && $urandom_range(0, 1) == 1) begin
        k = $urandom_range(0, pend_q.size() - 1);
        j = 0;
        while (pend_q[j][35:32] != pend_q[k][35:32]) begin
          j++;
        end
        m_r_id_i    = pend_q[j][35:32];
        m_r_data_i  = pend_q[j][31:0];
        // Response taken from bits 3:2 of the beat address
        m_r_resp_i  = resp_t'(pend_q[j][3:2]);
        m_r_valid_i = 1'b1;
        pend_q.delete(j);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Upstream driver
  // --------------------------------------------------------------------------
  initial begin : drive
    int   waited;
    logic accepted;
    void'($urandom(32'hb158_11ca));
    rst_n_i      = 1'b0;
    s_ar_id_i    = '0;
    s_ar_addr_i  = '0;
    s_ar_len_i   = '0;
    s_ar_size_i  = '0;
    s_ar_burst_i = '0;
    s_ar_valid_i = 1'b0;
    n_bursts     = 0;
    n_beats      = 0;
    for (int i = 0; i < 5 * MAX_BURSTS; i++) begin
      stim_mem[i] = '1;
    end
    $readmemh("tb/ar_stim.txt", stim_mem);
    while (n_bursts < MAX_BURSTS && stim_mem[5*n_bursts] != '1) begin
      n_beats += int'(stim_mem[5*n_bursts+2]) + 1;
      n_bursts++;
    end

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    for (int b = 0; b < n_bursts && stall == ""; b++) begin
      s_ar_id_i    = id_t'(stim_mem[5*b]);
      s_ar_addr_i  = stim_mem[5*b+1];
      s_ar_len_i   = len_t'(stim_mem[5*b+2]);
      s_ar_size_i  = size_t'(stim_mem[5*b+3]);
      s_ar_burst_i = burst_t'(stim_mem[5*b+4]);
      s_ar_valid_i = 1'b1;
      waited = 0;
      do begin
        @(posedge clk_i);
        accepted = s_ar_ready_o;
        waited++;
      end while (!accepted && waited < TIMEOUT);
      if (!accepted) begin
        stall = $sformatf("upstream AR %0d was never accepted", b);
      end
      @(negedge clk_i);
      s_ar_valid_i = 1'b0;
      // Sometimes an idle cycle between bursts
      if ($urandom_range(0, 1) == 1) begin
        @(negedge clk_i);
      end
    end

    waited = 0;
    while (stall == "" && i_tb_checker.r_cnt < n_beats) begin
      @(posedge clk_i);
      waited++;
      if (waited > TIMEOUT) begin
        stall = "R beats stopped before every burst was returned";
      end
    end
    repeat (2) @(posedge clk_i);

    errs = 0;
    if (stall != "") begin
      $display("Timeout, %s", stall);
      errs++;
    end
    errs += i_read_burst_splitter.i_tb_props.fail_cnt;
    errs = i_tb_checker.close_report(n_bursts, n_beats, errs);
    if (errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog/ar_splitter.sv ====
`timescale 1ns/1ns

module ar_splitter (
  input  logic             clk_i,
  input  logic             rst_n_i,

  input  bus_pkg::id_t     s_ar_id_i,
  input  bus_pkg::addr_t   s_ar_addr_i,
  input  bus_pkg::len_t    s_ar_len_i,
  input  bus_pkg::size_t   s_ar_size_i,
  input  bus_pkg::burst_t  s_ar_burst_i,
  input  logic             s_ar_valid_i,
  output logic             s_ar_ready_o,

  output bus_pkg::id_t     m_ar_id_o,
  output bus_pkg::addr_t   m_ar_addr_o,
  output bus_pkg::size_t   m_ar_size_o,
  output bus_pkg::burst_t  m_ar_burst_o,
  output logic             m_ar_valid_o,
  input  logic             m_ar_ready_i,

  alloc_if.requester       alloc
);
  import bus_pkg::*;

  typedef enum logic {IDLE, BUSY} state_e;

  state_e state_q, state_d;
  id_t    id_q;
  addr_t  addr_q, addr_d;
  len_t   len_q, len_d;
  size_t  size_q;
  burst_t burst_q;
  logic   single;
  logic   take;

  // Address of the beat after this one
  function automatic addr_t next_addr(addr_t addr, size_t size, burst_t burst);
    addr_t step;
    step = addr_t'(1) << size;
    if (burst == BURST_INCR) begin
      return addr + step;
    end
    return addr;
  endfunction

  assign single = (s_ar_len_i == '0);

  // A single beat only allocates once it can leave downstream right away
  assign alloc.id  = s_ar_id_i;
  assign alloc.len = s_ar_len_i;
  assign alloc.req = (state_q == IDLE) && s_ar_valid_i && (!single || m_ar_ready_i);

  assign s_ar_ready_o = alloc.req && alloc.gnt;
  assign take         = s_ar_ready_o && !single;

  // ------------------------------------------------------------------------
  // Beat generation
  // ------------------------------------------------------------------------
  always_comb begin
    m_ar_id_o    = id_q;
    m_ar_addr_o  = addr_q;
    m_ar_size_o  = size_q;
    m_ar_burst_o = burst_q;
    m_ar_valid_o = 1'b0;
    state_d      = state_q;
    addr_d       = addr_q;
    len_d        = len_q;

    if (state_q == IDLE) begin
      // First beat comes straight from the upstream request
      m_ar_id_o    = s_ar_id_i;
      m_ar_addr_o  = s_ar_addr_i;
      m_ar_size_o  = s_ar_size_i;
      m_ar_burst_o = s_ar_burst_i;
      m_ar_valid_o = s_ar_valid_i && alloc.gnt;
      if (take) begin
        state_d = BUSY;
        addr_d  = s_ar_addr_i;
        len_d   = s_ar_len_i;
        if (m_ar_ready_i) begin
          addr_d = next_addr(s_ar_addr_i, s_ar_size_i, s_ar_burst_i);
          len_d  = s_ar_len_i - 1'b1;
        end
      end
    end else begin
      m_ar_valid_o = 1'b1;
      if (m_ar_ready_i) begin
        if (len_q == '0) begin
          state_d = IDLE;
        end else begin
          addr_d = next_addr(addr_q, size_q, burst_q);
          len_d  = len_q - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    len_q  <= len_d;
    if (take) begin
      id_q    <= s_ar_id_i;
      size_q  <= s_ar_size_i;
      burst_q <= s_ar_burst_i;
    end
  end

endmodule

// ==== verilog/burst_slot.sv ====
`timescale 1ns/1ns

module burst_slot (
  input  logic   clk_i,
  input  logic   rst_n_i,
  slot_if.slot   port
);
  import bus_pkg::*;
  import split_pkg::*;

  id_t       id_q;
  beat_cnt_t count_q;

  // Remaining beats, zero means the slot is free
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (port.load) begin
      count_q <= port.load_cnt;
    end else if (port.dec) begin
      count_q <= count_q - 1'b1;
    end
  end

  // ID of the burst owning the slot
  always_ff @(posedge clk_i) begin
    if (port.load) begin
      id_q <= port.load_id;
    end
  end

  assign port.busy  = (count_q != '0);
  assign port.id    = id_q;
  assign port.count = count_q;

endmodule

// ==== verilog/bus_pkg.sv ====
package bus_pkg;

  // ------------------------------------------------------------------------
  // AXI read channel fields
  // ------------------------------------------------------------------------

  // Transaction ID
  typedef logic [3:0]  id_t;

  // Byte address
  typedef logic [31:0] addr_t;

  // Number of beats minus one
  typedef logic [7:0]  len_t;

  // Log2 of the bytes per beat
  typedef logic [2:0]  size_t;

  // Burst kind, WRAP is not supported here
  typedef logic [1:0]  burst_t;

  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;

  // R channel payload
  typedef logic [31:0] data_t;
  typedef logic [1:0]  resp_t;

endpackage

// ==== verilog/r_beat_tagger.sv ====
`timescale 1ns/1ns

module r_beat_tagger (
  input  bus_pkg::id_t    m_r_id_i,
  input  bus_pkg::data_t  m_r_data_i,
  input  bus_pkg::resp_t  m_r_resp_i,
  input  logic            m_r_valid_i,
  output logic            m_r_ready_o,

  output bus_pkg::id_t    s_r_id_o,
  output bus_pkg::data_t  s_r_data_o,
  output bus_pkg::resp_t  s_r_resp_o,
  output logic            s_r_last_o,
  output logic            s_r_valid_o,
  input  logic            s_r_ready_i,

  slot_if.drain           slots [split_pkg::MAX_TXNS]
);
  import split_pkg::*;

  logic [MAX_TXNS-1:0] hit;
  beat_cnt_t           count [MAX_TXNS];
  slot_idx_t           hit_idx;
  logic                match;
  logic                fire;

  // ------------------------------------------------------------------------
  // Slot lookup by ID
  // ------------------------------------------------------------------------
  for (genvar g = 0; g < MAX_TXNS; g++) begin : gen_drain
    assign hit[g]   = slots[g].busy && (slots[g].id == m_r_id_i);
    assign count[g] = slots[g].count;
    // Only one busy slot per ID, so at most one strobe
    assign slots[g].dec = fire && hit[g];
  end

  always_comb begin
    hit_idx = '0;
    for (int i = 0; i < MAX_TXNS; i++) begin
      if (hit[i]) begin
        hit_idx = slot_idx_t'(i);
      end
    end
  end

  assign match = |hit;

  // ------------------------------------------------------------------------
  // Beat forwarding
  // ------------------------------------------------------------------------
  assign s_r_id_o    = m_r_id_i;
  assign s_r_data_o  = m_r_data_i;
  assign s_r_resp_o  = m_r_resp_i;
  assign s_r_last_o  = match && (count[hit_idx] == beat_cnt_t'(1));
  assign s_r_valid_o = m_r_valid_i && match;

  // Unknown IDs are held off downstream
  assign m_r_ready_o = s_r_ready_i && match;

  assign fire = s_r_valid_o && s_r_ready_i;

endmodule

// ==== verilog/read_burst_splitter.sv ====
`timescale 1ns/1ns

module read_burst_splitter (
  input  logic             clk_i,
  input  logic             rst_n_i,

  // Upstream AR
  input  bus_pkg::id_t     s_ar_id_i,
  input  bus_pkg::addr_t   s_ar_addr_i,
  input  bus_pkg::len_t    s_ar_len_i,
  input  bus_pkg::size_t   s_ar_size_i,
  input  bus_pkg::burst_t  s_ar_burst_i,
  input  logic             s_ar_valid_i,
  output logic             s_ar_ready_o,

  // Downstream AR, always single beat
  output bus_pkg::id_t     m_ar_id_o,
  output bus_pkg::addr_t   m_ar_addr_o,
  output bus_pkg::size_t   m_ar_size_o,
  output bus_pkg::burst_t  m_ar_burst_o,
  output logic             m_ar_valid_o,
  input  logic             m_ar_ready_i,

  // Downstream R
  input  bus_pkg::id_t     m_r_id_i,
  input  bus_pkg::data_t   m_r_data_i,
  input  bus_pkg::resp_t   m_r_resp_i,
  input  logic             m_r_valid_i,
  output logic             m_r_ready_o,

  // Upstream R with rebuilt last
  output bus_pkg::id_t     s_r_id_o,
  output bus_pkg::data_t   s_r_data_o,
  output bus_pkg::resp_t   s_r_resp_o,
  output logic             s_r_last_o,
  output logic             s_r_valid_o,
  input  logic             s_r_ready_i
);
  import split_pkg::*;

  alloc_if alloc_bus ();
  slot_if  slot_bus [MAX_TXNS] ();

  ar_splitter i_ar_splitter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .s_ar_id_i    (s_ar_id_i),
    .s_ar_addr_i  (s_ar_addr_i),
    .s_ar_len_i   (s_ar_len_i),
    .s_ar_size_i  (s_ar_size_i),
    .s_ar_burst_i (s_ar_burst_i),
    .s_ar_valid_i (s_ar_valid_i),
    .s_ar_ready_o (s_ar_ready_o),
    .m_ar_id_o    (m_ar_id_o),
    .m_ar_addr_o  (m_ar_addr_o),
    .m_ar_size_o  (m_ar_size_o),
    .m_ar_burst_o (m_ar_burst_o),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .alloc        (alloc_bus)
  );

  slot_alloc i_slot_alloc (
    .alloc (alloc_bus),
    .slots (slot_bus)
  );

  for (genvar g = 0; g < MAX_TXNS; g++) begin : gen_slots
    burst_slot i_burst_slot (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .port    (slot_bus[g])
    );
  end

  r_beat_tagger i_r_beat_tagger (
    .m_r_id_i    (m_r_id_i),
    .m_r_data_i  (m_r_data_i),
    .m_r_resp_i  (m_r_resp_i),
    .m_r_valid_i (m_r_valid_i),
    .m_r_ready_o (m_r_ready_o),
    .s_r_id_o    (s_r_id_o),
    .s_r_data_o  (s_r_data_o),
    .s_r_resp_o  (s_r_resp_o),
    .s_r_last_o  (s_r_last_o),
    .s_r_valid_o (s_r_valid_o),
    .s_r_ready_i (s_r_ready_i),
    .slots       (slot_bus)
  );

endmodule

// ==== verilog/slot_alloc.sv ====
`timescale 1ns/1ns

module slot_alloc (
  alloc_if.granter alloc,
  slot_if.feed     slots [split_pkg::MAX_TXNS]
);
  import split_pkg::*;

  logic [MAX_TXNS-1:0] busy;
  logic [MAX_TXNS-1:0] id_hit;
  slot_idx_t           free_idx;
  logic                any_free;

  for (genvar g = 0; g < MAX_TXNS; g++) begin : gen_feed
    assign busy[g]   = slots[g].busy;
    // Same ID still in flight blocks a new burst
    assign id_hit[g] = slots[g].busy && (slots[g].id == alloc.id);

    assign slots[g].load     = alloc.req && alloc.gnt && (free_idx == slot_idx_t'(g));
    assign slots[g].load_id  = alloc.id;
    assign slots[g].load_cnt = beat_cnt_t'(alloc.len) + beat_cnt_t'(1);
  end

  // Lowest free slot wins
  always_comb begin
    free_idx = '0;
    for (int i = MAX_TXNS - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_idx = slot_idx_t'(i);
      end
    end
  end

  assign any_free  = ~&busy;
  assign alloc.gnt = any_free && !(|id_hit);

endmodule

// ==== verilog/split_ifs.sv ====
`timescale 1ns/1ns

// ----------------------------------------------------------------------------
// Allocation request from the AR side to the slot allocator
// ----------------------------------------------------------------------------
interface alloc_if;
  import bus_pkg::*;

  id_t  id;
  len_t len;
  logic req;
  logic gnt;

  modport requester (output id, len, req, input gnt);
  modport granter   (input id, len, req, output gnt);
endinterface

// ----------------------------------------------------------------------------
// One burst slot, fed by the allocator and drained by the R side
// ----------------------------------------------------------------------------
interface slot_if;
  import bus_pkg::*;
  import split_pkg::*;

  // Slot state
  logic      busy;
  id_t       id;
  beat_cnt_t count;

  // Load strobe with the new burst
  logic      load;
  id_t       load_id;
  beat_cnt_t load_cnt;

  // One beat handed upstream
  logic      dec;

  modport slot  (output busy, id, count, input load, load_id, load_cnt, dec);
  modport feed  (output load, load_id, load_cnt, input busy, id);
  modport drain (output dec, input busy, id, count);
endinterface

// ==== verilog/split_pkg.sv ====
package split_pkg;

  // Number of bursts that may be outstanding at once
  localparam int unsigned MAX_TXNS = 4;

  // Index into the row of burst slots
  typedef logic [1:0] slot_idx_t;

  // Remaining beats of a burst, one wider than len so len + 1 fits
  typedef logic [8:0] beat_cnt_t;

endpackage
